// ==== include/perf_defs.svh ====
`ifndef PERF_DEFS_SVH
`define PERF_DEFS_SVH

// Width of the live and snapshot counters
`define PERF_CNT_W 32

// One SPI command byte
`define PERF_CMD_W 8

// Read frame shifted out after a read command
`define PERF_FRAME_W `PERF_CNT_W

// Flops in front of the SPI pins
`define PERF_SYNC_STAGES 2

`endif

// ==== hdl/perf_pkg.sv ====
`include "perf_defs.svh"

package perf_pkg;

  // Counter value shared by live and snapshot registers
  typedef logic [`PERF_CNT_W-1:0] perf_cnt_t;

  // Host command bytes
  typedef enum logic [`PERF_CMD_W-1:0] {
    CMD_RD_INST   = 8'h01,
    CMD_RD_HIT    = 8'h02,
    CMD_RD_STATUS = 8'h03,
    CMD_CLEAR     = 8'h10,
    CMD_SNAP      = 8'h20,
    CMD_ENABLE    = 8'h40,
    CMD_DISABLE   = 8'h41
  } perf_cmd_e;

  // Source of the read frame
  typedef enum logic [1:0] {
    RSEL_INST,
    RSEL_HIT,
    RSEL_STATUS,
    RSEL_NONE
  } perf_rsel_e;

endpackage

// ==== hdl/perf_event_gen.sv ====
`timescale 1ns/1ns

module perf_event_gen (
  input  logic clk_l1,
  input  logic rst_n,
  input  logic enable,
  input  logic icc_halt,
  input  logic dcc_halt,
  input  logic wrong,
  output logic retire,
  output logic hit
);

  // Mispredict flag from the previous cycle
  logic wrong_dl;
  logic retire_c;
  logic hit_c;

  // An instruction retires when no cache stalls the pipe
  assign retire_c = enable && !icc_halt && !dcc_halt;

  // Two slots are flushed after a mispredict
  assign hit_c = retire_c && !wrong && !wrong_dl;

  always_ff @(posedge clk_l1) begin
    if (!rst_n) begin
      wrong_dl <= 1'b0;
      retire   <= 1'b0;
      hit      <= 1'b0;
    end else begin
      // Tracked during halts as well
      wrong_dl <= wrong;
      retire   <= retire_c;
      hit      <= hit_c;
    end
  end

endmodule

// ==== hdl/perf_counters.sv ====
`timescale 1ns/1ns

module perf_counters
  import perf_pkg::*;
(
  input  logic      clk_l1,
  input  logic      rst_n,
  input  logic      retire,
  input  logic      hit,
  input  logic      clear,
  input  logic      snap,
  output perf_cnt_t inst_snap,
  output perf_cnt_t hit_snap
);

  `include "perf_defs.svh"

  perf_cnt_t inst_cnt;
  perf_cnt_t hit_cnt;

  //////////////////////////////////////////////////
  // Live counters, wrap at full width
  //////////////////////////////////////////////////
  always_ff @(posedge clk_l1) begin
    if (!rst_n) begin
      inst_cnt <= '0;
      hit_cnt  <= '0;
    end else if (clear) begin
      // Clear has priority over events
      inst_cnt <= '0;
      hit_cnt  <= '0;
    end else begin
      if (retire) begin
        inst_cnt <= inst_cnt + 1'b1;
      end
      if (hit) begin
        hit_cnt <= hit_cnt + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Snapshot pair read by the host
  //////////////////////////////////////////////////
  always_ff @(posedge clk_l1) begin
    if (!rst_n || clear) begin
      inst_snap <= '0;
      hit_snap  <= '0;
    end else if (snap) begin
      // Both words frozen in the same cycle
      inst_snap <= inst_cnt;
      hit_snap  <= hit_cnt;
    end
  end

endmodule

// ==== hdl/perf_regs.sv ====
`timescale 1ns/1ns

module perf_regs
  import perf_pkg::*;
(
  input  logic                   clk_l1,
  input  logic                   rst_n,
  input  logic [`PERF_CMD_W-1:0] cmd,
  input  logic                   cmd_valid,
  input  perf_cnt_t              inst_snap,
  input  perf_cnt_t              hit_snap,
  output logic                   enable,
  output logic                   clear,
  output logic                   snap,
  output perf_cnt_t              rd_data
);

  `include "perf_defs.svh"

  perf_cmd_e  cmd_e;
  perf_rsel_e rsel;

  assign cmd_e = perf_cmd_e'(cmd);

  //////////////////////////////////////////////////
  // Control decode
  //////////////////////////////////////////////////

  // Single-cycle pulses straight from the decode
  assign clear = cmd_valid && (cmd_e == CMD_CLEAR);
  assign snap  = cmd_valid && (cmd_e == CMD_SNAP);

  always_ff @(posedge clk_l1) begin
    if (!rst_n) begin
      enable <= 1'b0;
    end else if (cmd_valid) begin
      if (cmd_e == CMD_ENABLE) begin
        enable <= 1'b1;
      end else if (cmd_e == CMD_DISABLE) begin
        enable <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Read path
  //////////////////////////////////////////////////
  always_comb begin
    case (cmd_e)
      CMD_RD_INST:   rsel = RSEL_INST;
      CMD_RD_HIT:    rsel = RSEL_HIT;
      CMD_RD_STATUS: rsel = RSEL_STATUS;
      default:       rsel = RSEL_NONE;
    endcase
  end

  // Unknown and write commands read back as zero
  always_comb begin
    case (rsel)
      RSEL_INST:   rd_data = inst_snap;
      RSEL_HIT:    rd_data = hit_snap;
      RSEL_STATUS: rd_data = {{(`PERF_CNT_W-1){1'b0}}, enable};
      default:     rd_data = '0;
    endcase
  end

endmodule

// ==== hdl/spi_slave.sv ====
`timescale 1ns/1ns

module spi_slave
  import perf_pkg::*;
(
  input  logic                   clk_l1,
  input  logic                   rst_n,
  input  logic                   sclk,
  input  logic                   ss_n,
  input  logic                   mosi,
  input  logic                   cpol,
  input  logic                   cpha,
  input  perf_cnt_t              rd_data,
  output logic [`PERF_CMD_W-1:0] cmd,
  output logic                   cmd_valid,
  output logic                   miso
);

  `include "perf_defs.svh"

  localparam int BIT_CNT_W = $clog2(`PERF_CMD_W);

  logic [`PERF_SYNC_STAGES-1:0] sclk_sync;
  logic [`PERF_SYNC_STAGES-1:0] ss_sync;
  logic [`PERF_SYNC_STAGES-1:0] mosi_sync;
  logic                         sclk_dl;
  logic                         sclk_s;
  logic                         mosi_s;
  logic                         ss_act;
  logic                         rise;
  logic                         fall;
  logic                         lead_edge;
  logic                         trail_edge;
  logic                         sample_edge;
  logic                         shift_edge;
  logic [BIT_CNT_W-1:0]         bit_cnt;
  logic [`PERF_CMD_W-1:0]       rx_sr;
  logic                         cmd_done;
  logic [`PERF_FRAME_W-1:0]     tx_sr;

  //////////////////////////////////////////////////
  // Pin synchronizers and edge detect
  //////////////////////////////////////////////////
  always_ff @(posedge clk_l1) begin
    if (!rst_n) begin
      // Idle clock level follows the cpol strap
      sclk_sync <= {`PERF_SYNC_STAGES{cpol}};
      sclk_dl   <= cpol;
      ss_sync   <= '1;
    end else begin
      sclk_sync <= {sclk_sync[`PERF_SYNC_STAGES-2:0], sclk};
      sclk_dl   <= sclk_s;
      ss_sync   <= {ss_sync[`PERF_SYNC_STAGES-2:0], ss_n};
    end
  end

  always_ff @(posedge clk_l1) begin
    mosi_sync <= {mosi_sync[`PERF_SYNC_STAGES-2:0], mosi};
  end

  assign sclk_s = sclk_sync[`PERF_SYNC_STAGES-1];
  assign mosi_s = mosi_sync[`PERF_SYNC_STAGES-1];
  assign ss_act = !ss_sync[`PERF_SYNC_STAGES-1];

  assign rise = ss_act && sclk_s && !sclk_dl;
  assign fall = ss_act && !sclk_s && sclk_dl;

  // Leading edge is the one leaving the idle level
  assign lead_edge  = cpol ? fall : rise;
  assign trail_edge = cpol ? rise : fall;

  // cpha picks which edge samples and which one drives
  assign sample_edge = cpha ? trail_edge : lead_edge;
  assign shift_edge  = cpha ? lead_edge : trail_edge;

  //////////////////////////////////////////////////
  // Command receive
  //////////////////////////////////////////////////
  always_ff @(posedge clk_l1) begin
    if (!rst_n || !ss_act) begin
      // Partial bytes are dropped when select goes away
      bit_cnt   <= '0;
      cmd_done  <= 1'b0;
      cmd_valid <= 1'b0;
    end else begin
      cmd_valid <= 1'b0;
      if (sample_edge && !cmd_done) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == BIT_CNT_W'(`PERF_CMD_W - 1)) begin
          cmd_done  <= 1'b1;
          cmd_valid <= 1'b1;
        end
      end
    end
  end

  // MSB first
  always_ff @(posedge clk_l1) begin
    if (sample_edge && !cmd_done) begin
      rx_sr <= {rx_sr[`PERF_CMD_W-2:0], mosi_s};
      if (bit_cnt == BIT_CNT_W'(`PERF_CMD_W - 1)) begin
        cmd <= {rx_sr[`PERF_CMD_W-2:0], mosi_s};
      end
    end
  end

  //////////////////////////////////////////////////
  // Read frame transmit
  //////////////////////////////////////////////////

  // Frame loaded while cmd_valid is high, rd_data decodes from cmd
  always_ff @(posedge clk_l1) begin
    if (cmd_valid) begin
      tx_sr <= rd_data;
    end else if (shift_edge && cmd_done) begin
      tx_sr <= {tx_sr[`PERF_FRAME_W-2:0], 1'b0};
    end
  end

  // First drive edge after the command byte puts out bit 31
  always_ff @(posedge clk_l1) begin
    if (!rst_n || !ss_act) begin
      miso <= 1'b0;
    end else if (shift_edge && cmd_done && !cmd_valid) begin
      miso <= tx_sr[`PERF_FRAME_W-1];
    end
  end

endmodule

// ==== hdl/perf_mon_top.sv ====
`timescale 1ns/1ns

module perf_mon_top
  import perf_pkg::*;
(
  input  logic clk_l1,
  input  logic rst_n,
  input  logic icc_halt,
  input  logic dcc_halt,
  input  logic wrong,
  input  logic sclk,
  input  logic ss_n,
  input  logic mosi,
  input  logic cpol,
  input  logic cpha,
  output logic miso
);

  `include "perf_defs.svh"

  logic                   enable;
  logic                   retire;
  logic                   hit;
  logic                   clear;
  logic                   snap;
  logic [`PERF_CMD_W-1:0] cmd;
  logic                   cmd_valid;
  perf_cnt_t              inst_snap;
  perf_cnt_t              hit_snap;
  perf_cnt_t              rd_data;

  //////////////////////////////////////////////////
  // Event path
  //////////////////////////////////////////////////
  perf_event_gen perf_event_gen_i (
    .clk_l1   (clk_l1),
    .rst_n    (rst_n),
    .enable   (enable),
    .icc_halt (icc_halt),
    .dcc_halt (dcc_halt),
    .wrong    (wrong),
    .retire   (retire),
    .hit      (hit)
  );

  perf_counters perf_counters_i (
    .clk_l1    (clk_l1),
    .rst_n     (rst_n),
    .retire    (retire),
    .hit       (hit),
    .clear     (clear),
    .snap      (snap),
    .inst_snap (inst_snap),
    .hit_snap  (hit_snap)
  );

  //////////////////////////////////////////////////
  // Host access
  //////////////////////////////////////////////////
  perf_regs perf_regs_i (
    .clk_l1    (clk_l1),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .inst_snap (inst_snap),
    .hit_snap  (hit_snap),
    .enable    (enable),
    .clear     (clear),
    .snap      (snap),
    .rd_data   (rd_data)
  );

  spi_slave spi_slave_i (
    .clk_l1    (clk_l1),
    .rst_n     (rst_n),
    .sclk      (sclk),
    .ss_n      (ss_n),
    .mosi      (mosi),
    .cpol      (cpol),
    .cpha      (cpha),
    .rd_data   (rd_data),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .miso      (miso)
  );

endmodule

// ==== tb/perf_mon_tb.sv ====
`timescale 1ns/1ns

module perf_mon_tb
  import perf_pkg::*;
;

  localparam int HALF = 8;
  localparam int NB   = 26;
  localparam int NR   = 4 * NB;
  localparam logic [31:0] SEED = 32'h3b5c;

  logic clk_l1 = 1'b0;
  logic rst_n, icc_halt, dcc_halt, wrong;
  logic sclk, ss_n, mosi, cpol, cpha;
  logic miso;

  // Base sequence, repeated once per SPI mode
  logic [7:0] b_cmd [NB] = '{CMD_RD_INST, CMD_RD_HIT, CMD_RD_STATUS, CMD_RD_INST, CMD_RD_HIT,
    CMD_SNAP, CMD_RD_INST, CMD_ENABLE, CMD_RD_STATUS, CMD_SNAP, CMD_RD_INST, CMD_RD_HIT,
    CMD_RD_INST, CMD_RD_HIT, CMD_SNAP, CMD_RD_INST, CMD_RD_HIT, 8'h7e, CMD_RD_STATUS,
    CMD_DISABLE, CMD_SNAP, CMD_RD_INST, CMD_RD_STATUS, CMD_CLEAR, CMD_RD_INST, CMD_RD_HIT};
  int b_ev [NB] = '{0, 0, 0, 0, 16, 24, 0, 0, 0, 64, 0, 0, 40, 0, 0, 0, 0, 12, 0,
    0, 30, 0, 0, 0, 0, 0};
  bit b_chk [NB] = '{1, 1, 1, 1, 1, 0, 1, 0, 1, 0, 1, 1, 1, 1, 0, 1, 1, 1, 1,
    0, 0, 1, 1, 0, 1, 1};

  logic [1:0] t_mode [NR];
  logic [7:0] t_cmd [NR];
  int         t_ev [NR];
  bit         t_chk [NR];

  // Reference model state
  logic [31:0] rng;
  logic        m_en, m_wdl;
  perf_cnt_t   m_inst, m_hit, m_isnap, m_hsnap;

  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int limit = 0;

  perf_mon_top perf_mon_top_i (
    .clk_l1   (clk_l1),
    .rst_n    (rst_n),
    .icc_halt (icc_halt),
    .dcc_halt (dcc_halt),
    .wrong    (wrong),
    .sclk     (sclk),
    .ss_n     (ss_n),
    .mosi     (mosi),
    .cpol     (cpol),
    .cpha     (cpha),
    .miso     (miso)
  );

  always #5 clk_l1 = ~clk_l1;

  always @(posedge clk_l1) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check(input perf_cnt_t got, input perf_cnt_t exp, input string msg);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("mismatch at %0t ns: %s, got %08h expected %08h", $time, msg, got, exp);
    end
  endtask

  task automatic wait_half();
    repeat (HALF) @(posedge clk_l1);
    #1;
  endtask

  //////////////////////////////////////////////////
  // Random pipeline events with the model beside them
  //////////////////////////////////////////////////
  task automatic run_events(input int n);
    logic ret;
    for (int k = 0; k < n; k++) begin
      @(posedge clk_l1);
      #1;
      rng = xorshift(rng);
      icc_halt = rng[0] & rng[1];
      dcc_halt = rng[7] & rng[9];
      wrong = rng[12] & rng[14];
      ret = m_en && !icc_halt && !dcc_halt;
      if (ret) m_inst = m_inst + 1;
      if (ret && !wrong && !m_wdl) m_hit = m_hit + 1;
      m_wdl = wrong;
    end
    // Stall held while the host talks, pipe drains
    @(posedge clk_l1);
    #1;
    icc_halt = 1'b1;
    dcc_halt = 1'b0;
    wrong = 1'b0;
    m_wdl = 1'b0;
    repeat (4) @(posedge clk_l1);
    #1;
  endtask

  function automatic perf_cnt_t expected_read(input logic [7:0] c);
    case (c)
      CMD_RD_INST:   return m_isnap;
      CMD_RD_HIT:    return m_hsnap;
      CMD_RD_STATUS: return {31'd0, m_en};
      default:       return '0;
    endcase
  endfunction

  task automatic apply_cmd(input logic [7:0] c);
    case (c)
      CMD_CLEAR: begin
        m_inst = '0;
        m_hit = '0;
        m_isnap = '0;
        m_hsnap = '0;
      end
      CMD_SNAP: begin
        m_isnap = m_inst;
        m_hsnap = m_hit;
      end
      CMD_ENABLE:  m_en = 1'b1;
      CMD_DISABLE: m_en = 1'b0;
      default: ;
    endcase
  endtask

  //////////////////////////////////////////////////
  // SPI master, MSB first, mode = {cpol, cpha}
  //////////////////////////////////////////////////
  task automatic spi_xfer(input logic [1:0] mode, input logic [7:0] cmd_b, input bit rd,
                          output perf_cnt_t data);
    int nbits;
    nbits = rd ? 40 : 8;
    data = '0;
    cpol = mode[1];
    cpha = mode[0];
    sclk = mode[1];
    wait_half();
    ss_n = 1'b0;
    // cpha 0 needs the first bit before the leading edge
    if (!cpha) mosi = cmd_b[7];
    wait_half();
    for (int i = 0; i < nbits; i++) begin
      if (!cpha && i >= 8) data = {data[30:0], miso};
      sclk = ~sclk;
      if (cpha) mosi = (i < 8) ? cmd_b[7 - i] : 1'b0;
      wait_half();
      if (cpha && i >= 8) data = {data[30:0], miso};
      sclk = ~sclk;
      if (!cpha) mosi = (i < 7) ? cmd_b[6 - i] : 1'b0;
      wait_half();
    end
    ss_n = 1'b1;
    mosi = 1'b0;
    wait_half();
  endtask

  initial begin
    perf_cnt_t got;
    perf_cnt_t exp;
    int err_before;
    int ev_sum;
    rst_n = 1'b0;
    icc_halt = 1'b1;
    dcc_halt = 1'b0;
    wrong = 1'b0;
    sclk = 1'b0;
    ss_n = 1'b1;
    mosi = 1'b0;
    cpol = 1'b0;
    cpha = 1'b0;
    m_en = 1'b0;
    m_wdl = 1'b0;
    m_inst = '0;
    m_hit = '0;
    m_isnap = '0;
    m_hsnap = '0;
    rng = SEED;
    ev_sum = 0;
    for (int m = 0; m < 4; m++) begin
      for (int b = 0; b < NB; b++) begin
        t_mode[m * NB + b] = 2'(m);
        t_cmd[m * NB + b] = b_cmd[b];
        t_ev[m * NB + b] = b_ev[b];
        t_chk[m * NB + b] = b_chk[b];
        ev_sum = ev_sum + b_ev[b];
      end
    end
    limit = 2 * (ev_sum + 600 * NR);

    repeat (2) @(posedge clk_l1);
    #1;
    rst_n = 1'b1;

    for (int i = 0; i < NR; i++) begin
      // Same event stream in every mode
      if (i % NB == 0) rng = SEED;
      err_before = errors;
      run_events(t_ev[i]);
      exp = expected_read(t_cmd[i]);
      spi_xfer(t_mode[i], t_cmd[i], t_chk[i], got);
      if (t_chk[i]) begin
        check(got, exp, "read frame");
      end
      apply_cmd(t_cmd[i]);
      $display("row %0d mode %0d cmd %02h events %0d: %s", i, t_mode[i], t_cmd[i], t_ev[i],
               (errors == err_before) ? "ok" : "error");
    end

    $display("rows %0d checks %0d errors %0d", NR, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+include
hdl/perf_pkg.sv
hdl/perf_event_gen.sv
hdl/perf_counters.sv
hdl/perf_regs.sv
hdl/spi_slave.sv
hdl/perf_mon_top.sv
tb/perf_mon_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the performance monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
EXE=perf_mon_sim

verilator --binary --timing --timescale 1ns/1ns \
  --top-module perf_mon_tb -f list.f -Mdir "$OBJ" -o "$EXE"
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

"./$OBJ/$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "TESTBENCH PASSED" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0
